/* design/cmdPkg.sv */
// Shared definitions for the command decoder; imported by wildcard in every module header
`default_nettype none

package cmdPkg;

  // -------------------------------------------------------------------------
  // Field widths
  // -------------------------------------------------------------------------
  localparam int opcodeWidth = 3;
  localparam int addrWidth = 6;
  localparam int dataWidth = 16;

  // Payload lengths in bits, per opcode
  localparam int wrPayloadLen = addrWidth + dataWidth;
  localparam int rdPayloadLen = addrWidth;
  localparam int runPayloadLen = 1;

  // Bit counter must hold the longest payload minus one
  localparam int cntWidth = $clog2(wrPayloadLen);

  // Status counter widths, sum plus two flags is the 16-bit word
  localparam int seuCntWidth = 6;
  localparam int fastErrCntWidth = 5;
  localparam int slowErrCntWidth = 3;

  // Triplicated words
  // Deserializer: sample bit, valid, 2-bit state, counter, opcode, payload
  localparam int deserTmrWidth = 4 + cntWidth + opcodeWidth + wrPayloadLen;
  // Dispatch: six strobes, run mode, address, write data
  localparam int dispTmrWidth = 7 + addrWidth + dataWidth;

  // -------------------------------------------------------------------------
  // Types
  // -------------------------------------------------------------------------
  typedef enum logic [opcodeWidth-1:0] {
    opReset   = 3'b000,
    opTrigger = 3'b001,
    opEcr     = 3'b010,
    opBcr     = 3'b011,
    opCal     = 3'b100,
    opRdReg   = 3'b101,
    opWrReg   = 3'b110,
    opRunMode = 3'b111
  } cmdOpcode_t;

  // One decoded command, payload right-aligned
  typedef struct packed {
    logic                    valid;
    cmdOpcode_t              opcode;
    logic [wrPayloadLen-1:0] payload;
  } cmdFrame_t;

  typedef struct packed {
    logic [seuCntWidth-1:0]     seuCnt;
    logic [fastErrCntWidth-1:0] fastErrCnt;
    logic [slowErrCntWidth-1:0] slowErrCnt;
    logic                       fastErr;
    logic                       slowErr;
  } statusFields_t;

  // Read-only status register, seen raw or by fields
  typedef union packed {
    logic [dataWidth-1:0] raw;
    statusFields_t        fields;
  } statusWord_t;

  // -------------------------------------------------------------------------
  // Payload length lookup and majority voting
  // -------------------------------------------------------------------------
  function automatic logic [cntWidth-1:0] payloadLen(input cmdOpcode_t op);
    case (op)
      opRdReg:   return cntWidth'(rdPayloadLen);
      opWrReg:   return cntWidth'(wrPayloadLen);
      opRunMode: return cntWidth'(runPayloadLen);
      default:   return '0;
    endcase
  endfunction

  // One voter and one mismatch check per triplicated word width
  function automatic logic [deserTmrWidth-1:0] vote3Deser(
    input logic [deserTmrWidth-1:0] a, b, c);
    return (a & b) | (a & c) | (b & c);
  endfunction

  function automatic logic differ3Deser(input logic [deserTmrWidth-1:0] a, b, c);
    return |((a ^ b) | (b ^ c));
  endfunction

  function automatic logic [dispTmrWidth-1:0] vote3Disp(
    input logic [dispTmrWidth-1:0] a, b, c);
    return (a & b) | (a & c) | (b & c);
  endfunction

  function automatic logic differ3Disp(input logic [dispTmrWidth-1:0] a, b, c);
    return |((a ^ b) | (b ^ c));
  endfunction

endpackage

`default_nettype wire

/* design/cmdDeserializer.sv */
// Input stage: samples DCI and turns the serial stream into one decoded frame per command
`timescale 1ns/1ps
`default_nettype none

module cmdDeserializer
  import cmdPkg::*;
(
  input  logic      CK,
  input  logic      RESET,
  input  logic      dci,
  output cmdFrame_t frame,
  output logic      seuFlag
);

  // -------------------------------------------------------------------------
  // Local types
  // -------------------------------------------------------------------------
  typedef enum logic [1:0] {
    stIdle    = 2'd0,
    stOpcode  = 2'd1,
    stPayload = 2'd2
  } deserState_t;

  // Everything that has to survive an upset, voted as one word
  typedef struct packed {
    logic                    dciQ;
    logic                    valid;
    deserState_t             state;
    logic [cntWidth-1:0]     bitCnt;
    cmdOpcode_t              opcode;
    logic [wrPayloadLen-1:0] payload;
  } deserWord_t;

  deserWord_t          copy1;
  deserWord_t          copy2;
  deserWord_t          copy3;
  deserWord_t          voted;
  deserWord_t          nextWord;
  cmdOpcode_t          newOpcode;
  logic [cntWidth-1:0] newLen;

  // -------------------------------------------------------------------------
  // Voting and upset detection
  // -------------------------------------------------------------------------
  assign voted = vote3Deser(copy1, copy2, copy3);

  // High in any cycle where one copy disagrees
  assign seuFlag = differ3Deser(copy1, copy2, copy3);

  // Opcode as it stands once the sampled bit is shifted in
  assign newOpcode = cmdOpcode_t'({voted.opcode[opcodeWidth-2:0], voted.dciQ});
  assign newLen = payloadLen(newOpcode);

  // -------------------------------------------------------------------------
  // Frame FSM
  // -------------------------------------------------------------------------
  // FSM works on the registered DCI bit
  // so a frame is complete one edge after its last bit is sampled
  always_comb begin
    nextWord = voted;
    nextWord.dciQ = dci;
    nextWord.valid = 1'b0;
    case (voted.state)
      stIdle: begin
        // Line idles low, first one is a start bit
        if (voted.dciQ) begin
          nextWord.state = stOpcode;
          nextWord.bitCnt = cntWidth'(opcodeWidth - 1);
        end
      end
      stOpcode: begin
        nextWord.opcode = newOpcode;
        if (voted.bitCnt == '0) begin
          if (newLen == '0) begin
            // Fast commands and ResetCmd end here
            nextWord.valid = 1'b1;
            nextWord.state = stIdle;
          end else begin
            nextWord.state = stPayload;
            nextWord.bitCnt = newLen - 1'b1;
          end
        end else begin
          nextWord.bitCnt = voted.bitCnt - 1'b1;
        end
      end
      stPayload: begin
        // MSB first, last bit lands in bit 0
        nextWord.payload = {voted.payload[wrPayloadLen-2:0], voted.dciQ};
        if (voted.bitCnt == '0) begin
          nextWord.valid = 1'b1;
          nextWord.state = stIdle;
        end else begin
          nextWord.bitCnt = voted.bitCnt - 1'b1;
        end
      end
      default: begin
        // Unused encoding, recover to idle
        nextWord.state = stIdle;
      end
    endcase
  end

  // -------------------------------------------------------------------------
  // Triplicated registers
  // -------------------------------------------------------------------------
  // Each copy reloads from the voted word
  always_ff @(posedge CK) begin
    if (RESET) begin
      copy1 <= '0;
      copy2 <= '0;
      copy3 <= '0;
    end else begin
      copy1 <= nextWord;
      copy2 <= nextWord;
      copy3 <= nextWord;
    end
  end

  // Frame fields only meaningful while valid is high
  assign frame = '{
    valid:   voted.valid,
    opcode:  voted.opcode,
    payload: voted.payload
  };

endmodule

`default_nettype wire

/* design/cmdDispatch.sv */
// Processing stage that gates decoded frames by run mode into strobes, registers and reject events
`timescale 1ns/1ps
`default_nettype none

module cmdDispatch
  import cmdPkg::*;
(
  input  logic                 CK,
  input  logic                 RESET,
  input  cmdFrame_t            frame,
  output logic                 trigger,
  output logic                 ecr,
  output logic                 bcr,
  output logic                 cal,
  output logic                 rdReg,
  output logic                 wrReg,
  output logic [addrWidth-1:0] addr,
  output logic [dataWidth-1:0] wrRegData,
  output logic                 runMode,
  output logic                 fastReject,
  output logic                 slowReject,
  output logic                 clearErrors,
  output logic                 seuFlag
);

  // Registered outputs kept in three copies
  typedef struct packed {
    logic                 trigger;
    logic                 ecr;
    logic                 bcr;
    logic                 cal;
    logic                 rdReg;
    logic                 wrReg;
    logic                 runMode;
    logic [addrWidth-1:0] addr;
    logic [dataWidth-1:0] wrRegData;
  } dispWord_t;

  dispWord_t copy1;
  dispWord_t copy2;
  dispWord_t copy3;
  dispWord_t voted;
  dispWord_t nextWord;
  logic      isFast;
  logic      isSlow;

  // -------------------------------------------------------------------------
  // Command classes and rejects
  // -------------------------------------------------------------------------
  assign isFast = frame.opcode inside {opTrigger, opEcr, opBcr, opCal};
  assign isSlow = frame.opcode inside {opRdReg, opWrReg, opReset};

  // Rejects go straight to the counters
  // so status moves at the same edge as the outputs
  assign fastReject = frame.valid && isFast && !voted.runMode;
  assign slowReject = frame.valid && isSlow && voted.runMode;
  assign clearErrors = frame.valid && (frame.opcode == opReset) && !voted.runMode;

  assign voted = vote3Disp(copy1, copy2, copy3);
  assign seuFlag = differ3Disp(copy1, copy2, copy3);

  // -------------------------------------------------------------------------
  // Next state of outputs and registers
  // -------------------------------------------------------------------------
  always_comb begin
    nextWord = voted;
    // Strobes last one cycle
    nextWord.trigger = 1'b0;
    nextWord.ecr = 1'b0;
    nextWord.bcr = 1'b0;
    nextWord.cal = 1'b0;
    nextWord.rdReg = 1'b0;
    nextWord.wrReg = 1'b0;
    if (frame.valid) begin
      case (frame.opcode)
        // Fast commands act in run mode only
        opTrigger: nextWord.trigger = voted.runMode;
        opEcr:     nextWord.ecr = voted.runMode;
        opBcr:     nextWord.bcr = voted.runMode;
        opCal:     nextWord.cal = voted.runMode;
        opRdReg: begin
          if (!voted.runMode) begin
            nextWord.rdReg = 1'b1;
            nextWord.addr = frame.payload[addrWidth-1:0];
          end
        end
        opWrReg: begin
          // Address sits above the data word
          if (!voted.runMode) begin
            nextWord.wrReg = 1'b1;
            nextWord.addr = frame.payload[wrPayloadLen-1 -: addrWidth];
            nextWord.wrRegData = frame.payload[dataWidth-1:0];
          end
        end
        opReset: begin
          if (!voted.runMode) begin
            nextWord.addr = '0;
            nextWord.wrRegData = '0;
          end
        end
        // Accepted in either mode
        opRunMode: nextWord.runMode = frame.payload[0];
      endcase
    end
  end

  always_ff @(posedge CK) begin
    if (RESET) begin
      copy1 <= '0;
      copy2 <= '0;
      copy3 <= '0;
    end else begin
      copy1 <= nextWord;
      copy2 <= nextWord;
      copy3 <= nextWord;
    end
  end

  // Voted copies drive the ports
  assign trigger = voted.trigger;
  assign ecr = voted.ecr;
  assign bcr = voted.bcr;
  assign cal = voted.cal;
  assign rdReg = voted.rdReg;
  assign wrReg = voted.wrReg;
  assign runMode = voted.runMode;
  assign addr = voted.addr;
  assign wrRegData = voted.wrRegData;

endmodule

`default_nettype wire

/* design/errorMonitor.sv */
// Output stage: counts upsets and rejected commands and presents them as the 16-bit status word
`timescale 1ns/1ps
`default_nettype none

module errorMonitor
  import cmdPkg::*;
(
  input  logic        CK,
  input  logic        RESET,
  input  logic        fastReject,
  input  logic        slowReject,
  input  logic        clearErrors,
  input  logic        deserSeu,
  input  logic        dispatchSeu,
  output statusWord_t status
);

  logic seuHit;
  logic seuFull;
  logic fastFull;
  logic slowFull;

  // -------------------------------------------------------------------------
  // Saturation detect
  // -------------------------------------------------------------------------
  // Either stage disagreeing counts once per cycle
  assign seuHit = deserSeu | dispatchSeu;

  assign seuFull = &status.fields.seuCnt;
  assign fastFull = &status.fields.fastErrCnt;
  assign slowFull = &status.fields.slowErrCnt;

  // -------------------------------------------------------------------------
  // Counters and sticky flags
  // -------------------------------------------------------------------------
  always_ff @(posedge CK) begin
    if (RESET) begin
      status.raw <= '0;
    end else if (clearErrors) begin
      // Accepted ResetCmd wins over any count in the same cycle
      status.raw <= '0;
    end else begin
      if (seuHit && !seuFull) begin
        status.fields.seuCnt <= status.fields.seuCnt + 1'b1;
      end
      // Fast command outside run mode
      if (fastReject) begin
        status.fields.fastErr <= 1'b1;
        if (!fastFull) begin
          status.fields.fastErrCnt <= status.fields.fastErrCnt + 1'b1;
        end
      end
      // Slow command inside run mode
      if (slowReject) begin
        status.fields.slowErr <= 1'b1;
        if (!slowFull) begin
          status.fields.slowErrCnt <= status.fields.slowErrCnt + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* design/cmdDecoderTop.sv */
// Top level of the command decoder; connects deserializer, dispatch and error monitor
`timescale 1ns/1ps
`default_nettype none

module cmdDecoderTop
  import cmdPkg::*;
(
  input  logic                 CK,
  input  logic                 RESET,
  input  logic                 dci,
  output logic                 trigger,
  output logic                 ecr,
  output logic                 bcr,
  output logic                 cal,
  output logic                 rdReg,
  output logic                 wrReg,
  output logic                 runMode,
  output logic [addrWidth-1:0] addr,
  output logic [dataWidth-1:0] wrRegData,
  output statusWord_t          status
);

  // -------------------------------------------------------------------------
  // Inter-stage nets
  // -------------------------------------------------------------------------
  cmdFrame_t frame;
  logic      deserSeu;
  logic      dispatchSeu;
  logic      fastReject;
  logic      slowReject;
  logic      clearErrors;

  // Serial line to frames
  cmdDeserializer deser (
    .CK      (CK),
    .RESET   (RESET),
    .dci     (dci),
    .frame   (frame),
    .seuFlag (deserSeu)
  );

  // Frames to strobes and registers
  cmdDispatch dispatch (
    .CK          (CK),
    .RESET       (RESET),
    .frame       (frame),
    .trigger     (trigger),
    .ecr         (ecr),
    .bcr         (bcr),
    .cal         (cal),
    .rdReg       (rdReg),
    .wrReg       (wrReg),
    .addr        (addr),
    .wrRegData   (wrRegData),
    .runMode     (runMode),
    .fastReject  (fastReject),
    .slowReject  (slowReject),
    .clearErrors (clearErrors),
    .seuFlag     (dispatchSeu)
  );

  // Error and upset counting
  errorMonitor monitor (
    .CK          (CK),
    .RESET       (RESET),
    .fastReject  (fastReject),
    .slowReject  (slowReject),
    .clearErrors (clearErrors),
    .deserSeu    (deserSeu),
    .dispatchSeu (dispatchSeu),
    .status      (status)
  );

endmodule

`default_nettype wire

/* tests/cmdModel.svh */
// Reference model of the decoder; included in the testbench module to predict outputs per command
`ifndef CMD_MODEL_SVH
`define CMD_MODEL_SVH

// Predicted state after every command applied so far
logic                 modelRunMode;
logic [addrWidth-1:0] modelAddr;
logic [dataWidth-1:0] modelData;
statusWord_t          modelStatus;

// Payload bits that follow the opcode
function automatic int payloadBitCount(input cmdOpcode_t op);
  case (op)
    opRdReg:   return 6;
    opWrReg:   return 22;
    opRunMode: return 1;
    default:   return 0;
  endcase
endfunction

// Same state as after RESET
task automatic clearModel();
  modelRunMode = 1'b0;
  modelAddr = '0;
  modelData = '0;
  modelStatus.raw = '0;
endtask

// Applies one command to the model
// Strobe order is trigger, ecr, bcr, cal, rdReg, wrReg
task automatic predictCommand(input cmdOpcode_t op, input logic [wrPayloadLen-1:0] payload,
                              output logic [5:0] strobes);
  logic isFast;
  logic isSlow;
  isFast = (op == opTrigger) || (op == opEcr) || (op == opBcr) || (op == opCal);
  isSlow = (op == opRdReg) || (op == opWrReg) || (op == opReset);
  strobes = '0;
  if (isFast && !modelRunMode) begin
    // Fast command while configuring
    modelStatus.fields.fastErr = 1'b1;
    if (modelStatus.fields.fastErrCnt != '1) begin
      modelStatus.fields.fastErrCnt = modelStatus.fields.fastErrCnt + 5'd1;
    end
  end else if (isSlow && modelRunMode) begin
    // Register access or ResetCmd while running
    modelStatus.fields.slowErr = 1'b1;
    if (modelStatus.fields.slowErrCnt != '1) begin
      modelStatus.fields.slowErrCnt = modelStatus.fields.slowErrCnt + 3'd1;
    end
  end else begin
    case (op)
      opTrigger: strobes[5] = 1'b1;
      opEcr:     strobes[4] = 1'b1;
      opBcr:     strobes[3] = 1'b1;
      opCal:     strobes[2] = 1'b1;
      opRdReg: begin
        strobes[1] = 1'b1;
        modelAddr = payload[5:0];
      end
      opWrReg: begin
        // Address first on the line, so it ends up on top
        strobes[0] = 1'b1;
        modelAddr = payload[21:16];
        modelData = payload[15:0];
      end
      opReset: begin
        modelAddr = '0;
        modelData = '0;
        modelStatus.raw = '0;
      end
      default: modelRunMode = payload[0];
    endcase
  end
endtask

`endif

/* tests/tbCmdDecoder.sv */
// Testbench for the command decoder; random command stream checked every cycle against a model
`timescale 1ns/1ps
`default_nettype none

module tbCmdDecoder
  import cmdPkg::*;
();

  // Command waiting for its output cycle
  typedef struct packed {
    int unsigned             cycle;
    cmdOpcode_t              op;
    logic [wrPayloadLen-1:0] payload;
  } pendingCmd_t;

  logic                 CK;
  logic                 RESET;
  logic                 dci;
  logic                 trigger;
  logic                 ecr;
  logic                 bcr;
  logic                 cal;
  logic                 rdReg;
  logic                 wrReg;
  logic                 runMode;
  logic [addrWidth-1:0] addr;
  logic [dataWidth-1:0] wrRegData;
  statusWord_t          status;

  int unsigned cycleCnt = 0;
  logic        checkEnable;
  pendingCmd_t pendQ[$];
  pendingCmd_t dueCmd;
  logic [5:0]  expStrobes;

  `include "cmdModel.svh"

  cmdDecoderTop dut_i (
    .CK        (CK),
    .RESET     (RESET),
    .dci       (dci),
    .trigger   (trigger),
    .ecr       (ecr),
    .bcr       (bcr),
    .cal       (cal),
    .rdReg     (rdReg),
    .wrReg     (wrReg),
    .runMode   (runMode),
    .addr      (addr),
    .wrRegData (wrRegData),
    .status    (status)
  );

  // ---------------------------------------------------------------------------
  // Clock and edge count
  // ---------------------------------------------------------------------------
  always #2 CK = ~CK;

  always @(posedge CK) begin
    cycleCnt <= cycleCnt + 1;
  end

  // ---------------------------------------------------------------------------
  // Failure reporting and compare tasks
  // ---------------------------------------------------------------------------
  task automatic failRun(input string why);
    $display("%s", why);
    $display("sim failed");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic expectStrobes(input logic [5:0] got, input logic [5:0] exp);
    if (got !== exp) begin
      failRun($sformatf("mismatch at %0t ns: strobes got %b expected %b", $time, got, exp));
    end
  endtask

  task automatic expectAddr(input logic [addrWidth-1:0] got, input logic [addrWidth-1:0] exp);
    if (got !== exp) begin
      failRun($sformatf("mismatch at %0t ns: addr got %h expected %h", $time, got, exp));
    end
  endtask

  task automatic expectData(input logic [dataWidth-1:0] got, input logic [dataWidth-1:0] exp);
    if (got !== exp) begin
      failRun($sformatf("mismatch at %0t ns: wrRegData got %h expected %h", $time, got, exp));
    end
  endtask

  task automatic expectRunMode(input logic got, input logic exp);
    if (got !== exp) begin
      failRun($sformatf("mismatch at %0t ns: runMode got %b expected %b", $time, got, exp));
    end
  endtask

  task automatic expectStatus(input statusWord_t got, input statusWord_t exp);
    if (got.raw !== exp.raw) begin
      failRun($sformatf("mismatch at %0t ns: status got %h expected %h", $time, got.raw,
                        exp.raw));
    end
  endtask

  // Outputs settle by the falling edge
  // a command is applied to the model in the cycle its outputs are due
  always @(negedge CK) begin
    if (checkEnable) begin
      expStrobes = '0;
      if (pendQ.size() > 0 && pendQ[0].cycle == cycleCnt) begin
        dueCmd = pendQ.pop_front();
        predictCommand(dueCmd.op, dueCmd.payload, expStrobes);
      end
      expectStrobes({trigger, ecr, bcr, cal, rdReg, wrReg}, expStrobes);
      expectAddr(addr, modelAddr);
      expectData(wrRegData, modelData);
      expectRunMode(runMode, modelRunMode);
      expectStatus(status, modelStatus);
    end
  end

  // ---------------------------------------------------------------------------
  // Stimulus
  // ---------------------------------------------------------------------------
  task automatic driveBit(input logic b);
    @(posedge CK);
    #1;
    dci = b;
  endtask

  task automatic idleCycles(input int unsigned n);
    repeat (n) driveBit(1'b0);
  endtask

  // Start bit, opcode MSB first, then payload MSB first
  task automatic sendCommand(input cmdOpcode_t op, input logic [wrPayloadLen-1:0] payload,
                             input int unsigned gap);
    logic [opcodeWidth-1:0] opBits;
    pendingCmd_t            entry;
    opBits = op;
    driveBit(1'b1);
    for (int i = opcodeWidth - 1; i >= 0; i--) begin
      driveBit(opBits[i]);
    end
    for (int i = payloadBitCount(op) - 1; i >= 0; i--) begin
      driveBit(payload[i]);
    end
    // Sampled at the next edge, outputs two edges after that
    entry.cycle = cycleCnt + 3;
    entry.op = op;
    entry.payload = payload;
    pendQ.push_back(entry);
    idleCycles(gap);
  endtask

  function automatic cmdOpcode_t fastOpcode();
    return cmdOpcode_t'(3'($urandom_range(4, 1)));
  endfunction

  // RdReg or WrReg, plus ResetCmd if asked
  function automatic cmdOpcode_t slowOpcode(input logic withReset);
    case ($urandom_range(withReset ? 2 : 1, 0))
      0:       return opRdReg;
      1:       return opWrReg;
      default: return opReset;
    endcase
  endfunction

  function automatic cmdOpcode_t anyOpcode();
    return cmdOpcode_t'(3'($urandom_range(7, 0)));
  endfunction

  function automatic logic [wrPayloadLen-1:0] freshPayload();
    return wrPayloadLen'($urandom);
  endfunction

  function automatic int unsigned idleGap();
    return $urandom_range(3, 0);
  endfunction

  task automatic waitDrained(input int unsigned limit);
    int unsigned waited;
    waited = 0;
    while (pendQ.size() != 0) begin
      @(negedge CK);
      waited++;
      if (waited > limit) begin
        failRun("timeout: predicted command outputs never came due");
      end
    end
  endtask

  initial begin
    void'($urandom(17));
    CK = 1'b0;
    RESET = 1'b1;
    dci = 1'b0;
    checkEnable = 1'b0;
    clearModel();
    repeat (5) @(posedge CK);
    #1;
    RESET = 1'b0;
    checkEnable = 1'b1;
    // Idle line, no strobes
    idleCycles(20);
    // Fast commands while configuring, enough to saturate the count
    repeat (40) sendCommand(fastOpcode(), freshPayload(), idleGap());
    // Register access while configuring
    repeat (20) sendCommand(slowOpcode(1'b0), freshPayload(), idleGap());
    // Run mode, fast commands back to back then spaced
    sendCommand(opRunMode, 22'd1, idleGap());
    repeat (30) sendCommand(fastOpcode(), freshPayload(), 0);
    repeat (20) sendCommand(fastOpcode(), freshPayload(), idleGap());
    // Rejected slow commands, saturates their count
    repeat (12) sendCommand(slowOpcode(1'b1), freshPayload(), idleGap());
    // Leave run mode and clear everything
    sendCommand(opRunMode, 22'd0, idleGap());
    sendCommand(opReset, '0, idleGap());
    // Mixed stream
    repeat (300) sendCommand(anyOpcode(), freshPayload(), idleGap());
    idleCycles(4);
    waitDrained(50);
    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
+incdir+tests
design/cmdPkg.sv
design/cmdDeserializer.sv
design/cmdDispatch.sv
design/errorMonitor.sv
design/cmdDecoderTop.sv
tests/tbCmdDecoder.sv

/* run.sh */
#!/bin/sh
# Build the decoder testbench with Verilator and run it.
# The exit status of the simulation is the result of the run.
cd "$(dirname "$0")" && \
verilator --binary --timing -Wno-fatal -f sources.f --top-module tbCmdDecoder && \
./obj_dir/VtbCmdDecoder || exit 1
